// File: src/alu_pkg.sv
/*
 * ALU package
 * Widths, operand types, operator encoding and the request and
 * response structures shared by the execution stage ALU.
 */
package alu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned XLEN      = 32;
    localparam int unsigned LANE_W    = 8;
    localparam int unsigned NUM_LANES = XLEN / LANE_W;
    localparam int unsigned SHAMT_W   = 5;

    typedef logic [XLEN-1:0]    xlen_t;
    typedef logic [LANE_W-1:0]  lane_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // --------------------------------------------------
    // Operators
    // --------------------------------------------------
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB,
        OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_SLT, OP_SLTU,
        OP_EQ, OP_NE, OP_LT, OP_LTU, OP_GE, OP_GEU,
        // Polar lane operations
        OP_PL_ADDSAT, OP_PL_SUBSAT, OP_PL_F, OP_PL_R, OP_PL_DECODE, OP_PL_EVAL
    } alu_op_e;

    // Request as presented by the issuing stage
    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
    } alu_req_t;

    typedef struct packed {
        xlen_t result;
        logic  branch_taken;
    } alu_rsp_t;

    // Handshake controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_ACK
    } ctrl_state_e;

endpackage

// File: src/alu_adder.sv
/*
 * ALU adder
 * One carry-chain adder for add, subtract and equality, plus the
 * signed/unsigned less-than and branch condition resolution.
 */
module alu_adder (
    input  logic              clk_i,
    input  logic              rst_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::xlen_t    operand_a_i,
    input  alu_pkg::xlen_t    operand_b_i,
    output alu_pkg::xlen_t    sum_o,
    output logic              less_o,
    output logic              branch_taken_o
);

    logic                    negate_b;
    logic                    signed_cmp;
    logic                    zero_flag;
    logic [alu_pkg::XLEN:0]  adder_in_a;
    logic [alu_pkg::XLEN:0]  adder_in_b;
    logic [alu_pkg::XLEN:0]  adder_ext;

    assign negate_b = (op_i == alu_pkg::OP_SUB) || (op_i == alu_pkg::OP_EQ) ||
                      (op_i == alu_pkg::OP_NE);

    // Carry-in rides in the extra low bit, so inverting b gives a - b
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(alu_pkg::XLEN + 1){negate_b}};
    assign adder_ext  = adder_in_a + adder_in_b;
    assign sum_o      = adder_ext[alu_pkg::XLEN:1];
    assign zero_flag  = ~|sum_o;

    // Sign extend only for the signed compares
    assign signed_cmp = (op_i == alu_pkg::OP_SLT) || (op_i == alu_pkg::OP_LT) ||
                        (op_i == alu_pkg::OP_GE);
    assign less_o = $signed({signed_cmp & operand_a_i[alu_pkg::XLEN-1], operand_a_i}) <
                    $signed({signed_cmp & operand_b_i[alu_pkg::XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            alu_pkg::OP_EQ:                  branch_taken_o = zero_flag;
            alu_pkg::OP_NE:                  branch_taken_o = ~zero_flag;
            alu_pkg::OP_LT, alu_pkg::OP_LTU: branch_taken_o = less_o;
            alu_pkg::OP_GE, alu_pkg::OP_GEU: branch_taken_o = ~less_o;
            default:                         branch_taken_o = 1'b1;
        endcase
    end

    // Subtract result must add back to operand a
    sub_inverse_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        (op_i == alu_pkg::OP_SUB) |-> ((sum_o + operand_b_i) == operand_a_i));

endmodule

// File: src/alu_shifter.sv
/*
 * ALU shifter
 * SLL, SRL and SRA around a single arithmetic right shifter,
 * with left shifts done by reversing the operand and the result.
 */
module alu_shifter (
    input  logic              clk_i,
    input  logic              rst_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::xlen_t    operand_a_i,
    input  alu_pkg::shamt_t   shamt_i,
    output alu_pkg::xlen_t    shift_result_o
);

    logic                    shift_left;
    logic                    shift_arith;
    alu_pkg::xlen_t          operand_a_rev;
    alu_pkg::xlen_t          shift_in;
    alu_pkg::xlen_t          left_result;
    logic [alu_pkg::XLEN:0]  shift_in_ext;
    logic [alu_pkg::XLEN:0]  right_result;

    assign shift_left  = (op_i == alu_pkg::OP_SLL);
    assign shift_arith = (op_i == alu_pkg::OP_SRA);

    for (genvar k = 0; k < alu_pkg::XLEN; k++) begin : gen_rev_in
        assign operand_a_rev[k] = operand_a_i[alu_pkg::XLEN-1-k];
    end

    assign shift_in = shift_left ? operand_a_rev : operand_a_i;

    // Top bit is the sign for SRA, zero otherwise
    assign shift_in_ext = {shift_arith & shift_in[alu_pkg::XLEN-1], shift_in};
    assign right_result = $unsigned($signed(shift_in_ext) >>> shamt_i);

    for (genvar k = 0; k < alu_pkg::XLEN; k++) begin : gen_rev_out
        assign left_result[k] = right_result[alu_pkg::XLEN-1-k];
    end

    assign shift_result_o = shift_left ? left_result : right_result[alu_pkg::XLEN-1:0];

    sra_sign_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        (op_i == alu_pkg::OP_SRA) |->
        (shift_result_o[alu_pkg::XLEN-1] == operand_a_i[alu_pkg::XLEN-1]));

endmodule

// File: src/polar_lanes.sv
/*
 * Polar lane unit
 * Signed 8-bit SIMD operations over the lanes of both operands,
 * with saturating add/subtract and the polar decoder primitives.
 */
module polar_lanes (
    input  logic              clk_i,
    input  logic              rst_i,
    input  alu_pkg::alu_op_e  op_i,
    input  alu_pkg::xlen_t    operand_a_i,
    input  alu_pkg::xlen_t    operand_b_i,
    output alu_pkg::xlen_t    polar_result_o
);

    localparam int unsigned LW = alu_pkg::LANE_W;

    // Saturation bounds symmetric around zero
    localparam alu_pkg::lane_t LANE_SAT_POS  = 8'h7F;
    localparam alu_pkg::lane_t LANE_SAT_NEG  = 8'h81;
    localparam alu_pkg::lane_t LANE_MOST_NEG = 8'h80;

    logic           b_low_one;
    logic           b_low_zero;
    alu_pkg::xlen_t addsat_v;
    alu_pkg::xlen_t subsat_v;
    alu_pkg::xlen_t f_v;
    alu_pkg::xlen_t r_v;
    alu_pkg::xlen_t decode_v;
    alu_pkg::xlen_t eval_v;

    // Control byte shared by R and DECODE
    assign b_low_one  = (operand_b_i[LW-1:0] == alu_pkg::lane_t'(1));
    assign b_low_zero = (operand_b_i[LW-1:0] == '0);

    for (genvar i = 0; i < alu_pkg::NUM_LANES; i++) begin : gen_lane
        alu_pkg::lane_t  a_l;
        alu_pkg::lane_t  b_l;
        alu_pkg::lane_t  abs_a;
        alu_pkg::lane_t  abs_b;
        alu_pkg::lane_t  mag;
        logic [LW:0]     sum9;
        logic [LW:0]     diff9;
        logic            sign_diff;

        assign a_l = operand_a_i[i*LW +: LW];
        assign b_l = operand_b_i[i*LW +: LW];

        // --------------------------------------------------
        // Saturating add and subtract
        // --------------------------------------------------
        assign sum9  = {a_l[LW-1], a_l} + {b_l[LW-1], b_l};
        assign diff9 = {a_l[LW-1], a_l} - {b_l[LW-1], b_l};

        assign addsat_v[i*LW +: LW] =
            ($signed(sum9) > $signed({1'b0, LANE_SAT_POS})) ? LANE_SAT_POS :
            ($signed(sum9) < $signed({1'b1, LANE_SAT_NEG})) ? LANE_SAT_NEG :
            sum9[LW-1:0];
        assign subsat_v[i*LW +: LW] =
            ($signed(diff9) > $signed({1'b0, LANE_SAT_POS})) ? LANE_SAT_POS :
            ($signed(diff9) < $signed({1'b1, LANE_SAT_NEG})) ? LANE_SAT_NEG :
            diff9[LW-1:0];

        // --------------------------------------------------
        // F takes the min magnitude with the product sign
        // --------------------------------------------------
        // -128 keeps magnitude 0x80, which compares as 128 unsigned
        assign abs_a     = a_l[LW-1] ? -a_l : a_l;
        assign abs_b     = b_l[LW-1] ? -b_l : b_l;
        assign sign_diff = a_l[LW-1] ^ b_l[LW-1];
        assign mag       = (abs_a > abs_b) ? abs_b : abs_a;

        assign f_v[i*LW +: LW]      = sign_diff ? -mag : mag;
        assign r_v[i*LW +: LW]      = (!b_low_one && a_l[LW-1]) ? alu_pkg::lane_t'(1) : '0;
        assign decode_v[i*LW +: LW] = b_low_zero ? a_l : '0;
        assign eval_v[i*LW +: LW]   = (a_l == alu_pkg::lane_t'(1)) ? '1 : '0;

        addsat_range_chk: assert property (@(posedge clk_i) disable iff (rst_i)
            (op_i == alu_pkg::OP_PL_ADDSAT) |->
            (polar_result_o[i*LW +: LW] != LANE_MOST_NEG));
    end

    always_comb begin
        case (op_i)
            alu_pkg::OP_PL_ADDSAT: polar_result_o = addsat_v;
            alu_pkg::OP_PL_SUBSAT: polar_result_o = subsat_v;
            alu_pkg::OP_PL_F:      polar_result_o = f_v;
            alu_pkg::OP_PL_R:      polar_result_o = r_v;
            alu_pkg::OP_PL_DECODE: polar_result_o = decode_v;
            alu_pkg::OP_PL_EVAL:   polar_result_o = eval_v;
            default:               polar_result_o = '0;
        endcase
    end

endmodule

// File: src/alu_issue_ctrl.sv
/*
 * ALU issue controller
 * Four-phase req/ack FSM, operand capture, final result selection
 * with the bitwise logic operations, and the response register.
 */
module alu_issue_ctrl (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  alu_pkg::alu_req_t req_data_i,
    output logic              ack_o,
    output alu_pkg::alu_rsp_t rsp_o,
    output alu_pkg::alu_req_t op_q_o,
    input  alu_pkg::xlen_t    sum_i,
    input  logic              less_i,
    input  logic              branch_taken_i,
    input  alu_pkg::xlen_t    shift_result_i,
    input  alu_pkg::xlen_t    polar_result_i
);

    alu_pkg::ctrl_state_e state_q;
    alu_pkg::alu_req_t    op_q;
    alu_pkg::alu_rsp_t    rsp_q;
    alu_pkg::alu_rsp_t    rsp_d;
    alu_pkg::xlen_t       result_d;

    // --------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= alu_pkg::ST_IDLE;
            rsp_q   <= '0;
        end else begin
            case (state_q)
                alu_pkg::ST_IDLE: begin
                    if (req_i) begin
                        state_q <= alu_pkg::ST_EXEC;
                    end
                end
                alu_pkg::ST_EXEC: begin
                    // Units settle from op_q within this cycle
                    state_q <= alu_pkg::ST_ACK;
                    rsp_q   <= rsp_d;
                end
                alu_pkg::ST_ACK: begin
                    if (!req_i) begin
                        state_q <= alu_pkg::ST_IDLE;
                    end
                end
                default: state_q <= alu_pkg::ST_IDLE;
            endcase
        end
    end

    // Operand capture on acceptance
    always_ff @(posedge clk_i) begin
        if ((state_q == alu_pkg::ST_IDLE) && req_i) begin
            op_q <= req_data_i;
        end
    end

    // --------------------------------------------------
    // Result mux
    // --------------------------------------------------
    always_comb begin
        case (op_q.op)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB: result_d = sum_i;
            alu_pkg::OP_AND: result_d = op_q.operand_a & op_q.operand_b;
            alu_pkg::OP_OR:  result_d = op_q.operand_a | op_q.operand_b;
            alu_pkg::OP_XOR: result_d = op_q.operand_a ^ op_q.operand_b;
            alu_pkg::OP_SLL, alu_pkg::OP_SRL, alu_pkg::OP_SRA: result_d = shift_result_i;
            alu_pkg::OP_SLT, alu_pkg::OP_SLTU: result_d = {{(alu_pkg::XLEN-1){1'b0}}, less_i};
            alu_pkg::OP_PL_ADDSAT, alu_pkg::OP_PL_SUBSAT, alu_pkg::OP_PL_F,
            alu_pkg::OP_PL_R, alu_pkg::OP_PL_DECODE, alu_pkg::OP_PL_EVAL:
                result_d = polar_result_i;
            // Branches report only the taken bit
            default: result_d = '0;
        endcase
    end

    always_comb begin
        rsp_d.result       = result_d;
        rsp_d.branch_taken = branch_taken_i;
    end

    assign ack_o  = (state_q == alu_pkg::ST_ACK);
    assign rsp_o  = rsp_q;
    assign op_q_o = op_q;

    // Ack only ever answers a pending request
    ack_after_req_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ack_o) |-> $past(req_i));

    rsp_hold_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_o && $past(ack_o)) |-> $stable(rsp_o));

endmodule

// File: src/alu_top.sv
/*
 * ALU top level
 * Handshake controller and the adder, shifter and polar lane units.
 */
module alu_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_i,
    input  alu_pkg::alu_req_t req_data_i,
    output logic              ack_o,
    output alu_pkg::alu_rsp_t rsp_o
);

    alu_pkg::alu_req_t op_q;
    alu_pkg::xlen_t    sum;
    logic              less;
    logic              branch_taken;
    alu_pkg::xlen_t    shift_result;
    alu_pkg::xlen_t    polar_result;

    alu_issue_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .req_data_i     (req_data_i),
        .ack_o          (ack_o),
        .rsp_o          (rsp_o),
        .op_q_o         (op_q),
        .sum_i          (sum),
        .less_i         (less),
        .branch_taken_i (branch_taken),
        .shift_result_i (shift_result),
        .polar_result_i (polar_result)
    );

    alu_adder u_adder (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_i           (op_q.op),
        .operand_a_i    (op_q.operand_a),
        .operand_b_i    (op_q.operand_b),
        .sum_o          (sum),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    // Shift amount is the low bits of operand b
    alu_shifter u_shifter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_i           (op_q.op),
        .operand_a_i    (op_q.operand_a),
        .shamt_i        (op_q.operand_b[alu_pkg::SHAMT_W-1:0]),
        .shift_result_o (shift_result)
    );

    polar_lanes u_polar (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .op_i           (op_q.op),
        .operand_a_i    (op_q.operand_a),
        .operand_b_i    (op_q.operand_b),
        .polar_result_o (polar_result)
    );

endmodule

// File: sim/alu_ref_model.svh
/*
 * ALU reference model
 * Expected result and branch outcome for every operator,
 * written straight from the operator rules.
 */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Clamp to the symmetric polar range
function automatic int clamp_polar(int v);
    if (v > 127) begin
        return 127;
    end
    if (v < -127) begin
        return -127;
    end
    return v;
endfunction

// One 8-bit lane with ctrl as the low byte of operand b
function automatic alu_pkg::lane_t model_lane(alu_pkg::alu_op_e op, alu_pkg::lane_t a,
                                              alu_pkg::lane_t b, alu_pkg::lane_t ctrl);
    int sa;
    int sb;
    int ma;
    int mb;
    int mn;
    int res;

    sa = int'($signed(a));
    sb = int'($signed(b));
    ma = (sa < 0) ? -sa : sa;
    mb = (sb < 0) ? -sb : sb;
    mn = (ma > mb) ? mb : ma;
    case (op)
        alu_pkg::OP_PL_ADDSAT: res = clamp_polar(sa + sb);
        alu_pkg::OP_PL_SUBSAT: res = clamp_polar(sa - sb);
        alu_pkg::OP_PL_F:      res = ((sa < 0) != (sb < 0)) ? -mn : mn;
        alu_pkg::OP_PL_R:      res = (ctrl == 8'h01) ? 0 : ((sa < 0) ? 1 : 0);
        alu_pkg::OP_PL_DECODE: res = (ctrl == 8'h00) ? sa : 0;
        alu_pkg::OP_PL_EVAL:   res = (a == 8'h01) ? 255 : 0;
        default:               res = 0;
    endcase
    return alu_pkg::lane_t'(res);
endfunction

function automatic alu_pkg::xlen_t model_result(alu_pkg::alu_op_e op, alu_pkg::xlen_t a,
                                                alu_pkg::xlen_t b);
    alu_pkg::xlen_t r;
    alu_pkg::shamt_t sh;

    sh = b[alu_pkg::SHAMT_W-1:0];
    r  = '0;
    case (op)
        alu_pkg::OP_ADD:  r = a + b;
        alu_pkg::OP_SUB:  r = a - b;
        alu_pkg::OP_AND:  r = a & b;
        alu_pkg::OP_OR:   r = a | b;
        alu_pkg::OP_XOR:  r = a ^ b;
        alu_pkg::OP_SLL:  r = a << sh;
        alu_pkg::OP_SRL:  r = a >> sh;
        alu_pkg::OP_SRA:  r = $signed(a) >>> sh;
        alu_pkg::OP_SLT:  r = alu_pkg::xlen_t'($signed(a) < $signed(b));
        alu_pkg::OP_SLTU: r = alu_pkg::xlen_t'(a < b);
        alu_pkg::OP_PL_ADDSAT, alu_pkg::OP_PL_SUBSAT, alu_pkg::OP_PL_F,
        alu_pkg::OP_PL_R, alu_pkg::OP_PL_DECODE, alu_pkg::OP_PL_EVAL: begin
            for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
                r[i*alu_pkg::LANE_W +: alu_pkg::LANE_W] =
                    model_lane(op, a[i*alu_pkg::LANE_W +: alu_pkg::LANE_W],
                               b[i*alu_pkg::LANE_W +: alu_pkg::LANE_W], b[7:0]);
            end
        end
        // Branches give zero
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic model_branch(alu_pkg::alu_op_e op, alu_pkg::xlen_t a,
                                      alu_pkg::xlen_t b);
    case (op)
        alu_pkg::OP_EQ:  return a == b;
        alu_pkg::OP_NE:  return a != b;
        alu_pkg::OP_LT:  return $signed(a) < $signed(b);
        alu_pkg::OP_LTU: return a < b;
        alu_pkg::OP_GE:  return $signed(a) >= $signed(b);
        alu_pkg::OP_GEU: return a >= b;
        default:         return 1'b1;
    endcase
endfunction

`endif

// File: sim/tb_alu.sv
/*
 * ALU testbench
 * Random operations through the four-phase handshake, checked
 * against the reference model, with back-pressure holds.
 */
module tb_alu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT = 20;

    logic              clk_i;
    logic              rst_i;
    logic              req_i;
    alu_pkg::alu_req_t req_data_i;
    logic              ack_o;
    alu_pkg::alu_rsp_t rsp_o;
    integer            seed;

    `include "alu_ref_model.svh"

    alu_top dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .rsp_o      (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_result(string name, alu_pkg::xlen_t exp, alu_pkg::xlen_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_branch(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_ack(logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: ack_o expected %b actual %b", $time, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("Mismatch at %0t: %s expected %0d cycles actual %0d cycles",
                     $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic alu_pkg::xlen_t pick_operand();
        int sel;

        sel = {$random(seed)} % 8;
        case (sel)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7FFF_FFFF;
            default: return $random(seed);
        endcase
    endfunction

    // Lanes biased toward the saturation and sign corners
    function automatic alu_pkg::xlen_t pick_lane_word();
        int             sel;
        alu_pkg::lane_t lane;
        alu_pkg::xlen_t w;

        w = '0;
        for (int i = 0; i < alu_pkg::NUM_LANES; i++) begin
            sel = {$random(seed)} % 8;
            case (sel)
                0:       lane = 8'h80;
                1:       lane = 8'h7F;
                2:       lane = 8'h81;
                3:       lane = 8'h01;
                4:       lane = 8'h00;
                default: lane = alu_pkg::lane_t'($random(seed));
            endcase
            w[i*alu_pkg::LANE_W +: alu_pkg::LANE_W] = lane;
        end
        return w;
    endfunction

    function automatic alu_pkg::alu_op_e arith_op(int idx);
        case (idx)
            0:       return alu_pkg::OP_ADD;
            1:       return alu_pkg::OP_SUB;
            2:       return alu_pkg::OP_AND;
            3:       return alu_pkg::OP_OR;
            4:       return alu_pkg::OP_XOR;
            5:       return alu_pkg::OP_SLL;
            6:       return alu_pkg::OP_SRL;
            7:       return alu_pkg::OP_SRA;
            8:       return alu_pkg::OP_SLT;
            default: return alu_pkg::OP_SLTU;
        endcase
    endfunction

    function automatic alu_pkg::alu_op_e branch_op(int idx);
        case (idx)
            0:       return alu_pkg::OP_EQ;
            1:       return alu_pkg::OP_NE;
            2:       return alu_pkg::OP_LT;
            3:       return alu_pkg::OP_LTU;
            4:       return alu_pkg::OP_GE;
            default: return alu_pkg::OP_GEU;
        endcase
    endfunction

    function automatic alu_pkg::alu_op_e polar_op(int idx);
        case (idx)
            0:       return alu_pkg::OP_PL_ADDSAT;
            1:       return alu_pkg::OP_PL_SUBSAT;
            2:       return alu_pkg::OP_PL_F;
            3:       return alu_pkg::OP_PL_R;
            4:       return alu_pkg::OP_PL_DECODE;
            default: return alu_pkg::OP_PL_EVAL;
        endcase
    endfunction

    // --------------------------------------------------
    // Handshake driver
    // --------------------------------------------------
    // Entered 1 ns after a rising edge with ack_o low
    task automatic run_op(alu_pkg::alu_op_e op, alu_pkg::xlen_t a, alu_pkg::xlen_t b,
                          int hold);
        alu_pkg::xlen_t    exp_result;
        logic              exp_branch;
        alu_pkg::alu_rsp_t held;
        int                cycles;

        exp_result = model_result(op, a, b);
        exp_branch = model_branch(op, a, b);
        req_data_i.op        = op;
        req_data_i.operand_a = a;
        req_data_i.operand_b = b;
        req_i = 1'b1;

        cycles = 0;
        while (!ack_o) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (!ack_o && cycles >= ACK_TIMEOUT) begin
                $display("Timeout: ack_o did not rise within %0d cycles of req_i",
                         ACK_TIMEOUT);
                stop_with_failure();
            end
        end
        check_latency("ack_o rise", 2, cycles);
        check_result("rsp_o.result", exp_result, rsp_o.result);
        check_branch("rsp_o.branch_taken", exp_branch, rsp_o.branch_taken);

        // Back-pressure holds the response
        held = rsp_o;
        repeat (hold) begin
            @(posedge clk_i);
            #1;
            check_ack(1'b1, ack_o);
            check_result("rsp_o.result", held.result, rsp_o.result);
            check_branch("rsp_o.branch_taken", held.branch_taken, rsp_o.branch_taken);
        end

        req_i = 1'b0;
        cycles = 0;
        while (ack_o) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (ack_o && cycles >= ACK_TIMEOUT) begin
                $display("Timeout: ack_o did not fall within %0d cycles after req_i dropped",
                         ACK_TIMEOUT);
                stop_with_failure();
            end
        end
        check_latency("ack_o fall", 1, cycles);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        alu_pkg::alu_op_e op;
        alu_pkg::xlen_t   a;
        alu_pkg::xlen_t   b;
        int               sel;

        seed       = 43448;
        rst_i      = 1'b1;
        req_i      = 1'b0;
        req_data_i = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Idle outputs after reset
        @(posedge clk_i);
        #1;
        check_ack(1'b0, ack_o);
        check_result("rsp_o.result", '0, rsp_o.result);
        check_branch("rsp_o.branch_taken", 1'b0, rsp_o.branch_taken);

        for (int n = 0; n < 500; n++) begin
            op = arith_op({$random(seed)} % 10);
            a  = pick_operand();
            b  = pick_operand();
            run_op(op, a, b, {$random(seed)} % 7);
        end

        // Branches with equal operands a quarter of the time
        for (int n = 0; n < 300; n++) begin
            op  = branch_op({$random(seed)} % 6);
            a   = pick_operand();
            sel = {$random(seed)} % 4;
            b   = (sel == 0) ? a : pick_operand();
            run_op(op, a, b, {$random(seed)} % 7);
        end

        // Polar lanes with the control byte forced to 0 or 1
        for (int n = 0; n < 300; n++) begin
            op  = polar_op({$random(seed)} % 6);
            a   = pick_lane_word();
            b   = pick_lane_word();
            sel = {$random(seed)} % 4;
            if (sel == 0) begin
                b[7:0] = 8'h00;
            end else if (sel == 1) begin
                b[7:0] = 8'h01;
            end
            run_op(op, a, b, {$random(seed)} % 7);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+sim
src/alu_pkg.sv
src/alu_adder.sv
src/alu_shifter.sv
src/polar_lanes.sv
src/alu_issue_ctrl.sv
src/alu_top.sv
sim/tb_alu.sv

// File: Makefile
# Verilator build and run of the ALU testbench

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_alu -f build.f
	./obj_dir/Vtb_alu | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir
